// File: hw/arith_unit.sv
// single-cycle ALU and jump link value, driving the arithmetic completion port
`timescale 1ns/1ps

module arith_unit (
  input  exec_pkg::issue_t   issue,
  output exec_pkg::cb_port_t cb
);

  logic              is_alu;
  logic              is_jump;
  logic [4:0]        shamt;
  exec_pkg::alu_op_e op;
  exec_pkg::word_t   alu_res;
  exec_pkg::word_t   link;

  assign is_alu  = (issue.unit == exec_pkg::UNIT_ALU);
  assign is_jump = (issue.unit == exec_pkg::UNIT_JUMP);
  assign op      = exec_pkg::alu_op_e'(issue.op);

  // shifts only look at the low five bits
  assign shamt = issue.port_b[4:0];
  assign link  = issue.pc + 32'd4;

  always_comb begin
    case (op)
      exec_pkg::ALU_ADD:  alu_res = issue.port_a + issue.port_b;
      exec_pkg::ALU_SUB:  alu_res = issue.port_a - issue.port_b;
      exec_pkg::ALU_AND:  alu_res = issue.port_a & issue.port_b;
      exec_pkg::ALU_OR:   alu_res = issue.port_a | issue.port_b;
      exec_pkg::ALU_XOR:  alu_res = issue.port_a ^ issue.port_b;
      exec_pkg::ALU_SLL:  alu_res = issue.port_a << shamt;
      exec_pkg::ALU_SRL:  alu_res = issue.port_a >> shamt;
      exec_pkg::ALU_SRA:  alu_res = exec_pkg::word_t'($signed(issue.port_a) >>> shamt);
      exec_pkg::ALU_SLT: begin
        alu_res = exec_pkg::word_t'($signed(issue.port_a) < $signed(issue.port_b));
      end
      exec_pkg::ALU_SLTU: begin
        alu_res = exec_pkg::word_t'(issue.port_a < issue.port_b);
      end
      default:            alu_res = '0;
    endcase
  end

  // completes in the issue cycle, jumps write the return address
  always_comb begin
    cb       = '0;
    cb.ready = is_alu | is_jump;
    cb.wen   = is_alu | is_jump;
    cb.rd    = issue.rd;
    cb.index = issue.index;
    cb.wdata = is_jump ? link : alu_res;
  end

endmodule

// File: hw/branch_resolve.sv
// branch condition, branch and jump targets, mispredict redirect and its registered flag
`timescale 1ns/1ps

module branch_resolve (
  input  logic                CLK,
  input  logic                nRST,
  input  exec_pkg::issue_t    issue,
  output exec_pkg::cb_port_t  cb,
  output exec_pkg::redirect_t redirect,
  output logic                mispredict_ff
);

  logic             is_branch;
  logic             is_jump;
  logic             taken;
  exec_pkg::br_op_e op;
  exec_pkg::word_t  br_target;
  exec_pkg::word_t  jalr_sum;
  exec_pkg::word_t  jump_target;
  exec_pkg::word_t  pc_plus4;

  assign is_branch = (issue.unit == exec_pkg::UNIT_BRANCH);
  assign is_jump   = (issue.unit == exec_pkg::UNIT_JUMP);
  assign op        = exec_pkg::br_op_e'(issue.op[2:0]);

  always_comb begin
    case (op)
      exec_pkg::BR_EQ:  taken = (issue.port_a == issue.port_b);
      exec_pkg::BR_NE:  taken = (issue.port_a != issue.port_b);
      exec_pkg::BR_LT:  taken = ($signed(issue.port_a) < $signed(issue.port_b));
      exec_pkg::BR_GE:  taken = ($signed(issue.port_a) >= $signed(issue.port_b));
      exec_pkg::BR_LTU: taken = (issue.port_a < issue.port_b);
      exec_pkg::BR_GEU: taken = (issue.port_a >= issue.port_b);
      default:          taken = 1'b0;
    endcase
  end

  assign br_target = issue.pc + issue.imm;
  assign pc_plus4  = issue.pc + 32'd4;
  assign jalr_sum  = issue.port_a + issue.imm;

  // jalr drops bit 0 of the sum
  assign jump_target = (op == exec_pkg::BR_JALR) ? (jalr_sum & ~exec_pkg::word_t'(1)) :
                                                  br_target;

  // jumps always redirect, branches only when the prediction was wrong
  always_comb begin
    redirect.valid = is_jump | (is_branch & (taken != issue.prediction));
    if (is_jump) begin
      redirect.addr = jump_target;
    end else if (taken) begin
      redirect.addr = br_target;
    end else begin
      redirect.addr = pc_plus4;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (~nRST) begin
      mispredict_ff <= 1'b0;
    end else begin
      mispredict_ff <= redirect.valid;
    end
  end

  // branches retire without a register write
  always_comb begin
    cb       = '0;
    cb.ready = is_branch;
    cb.rd    = issue.rd;
    cb.index = issue.index;
  end

endmodule

// File: hw/div_unit.sv
// iterative restoring divider with FSM, captured tag and busy flag, on the divide port
`timescale 1ns/1ps
`include "exec_macros.svh"

module div_unit (
  input  logic               CLK,
  input  logic               nRST,
  input  exec_pkg::issue_t   issue,
  output exec_pkg::cb_port_t cb,
  output logic               busy
);

  localparam int CW = $clog2(`DIV_ITERS + 1);

  exec_pkg::div_state_e state;
  logic [CW-1:0]        cnt;
  logic                 start;
  logic                 op_signed;
  logic                 a_neg;
  logic                 b_neg;
  exec_pkg::div_op_e    op;

  // captured at start
  exec_pkg::div_op_e    op_q;
  exec_pkg::reg_idx_t   rd_q;
  exec_pkg::cb_index_t  index_q;
  exec_pkg::word_t      dividend_q;
  exec_pkg::word_t      divisor_q;
  exec_pkg::word_t      quo_q;
  exec_pkg::word_t      rem_q;
  logic                 neg_quo_q;
  logic                 neg_rem_q;
  logic                 zero_q;
  logic                 ovf_q;

  logic [`XLEN:0]       rem_shift;
  logic [`XLEN:0]       diff;
  exec_pkg::word_t      quo_fix;
  exec_pkg::word_t      rem_fix;
  exec_pkg::word_t      result;
  logic                 ready_q;
  exec_pkg::word_t      result_q;

  assign op        = exec_pkg::div_op_e'(issue.op[1:0]);
  assign op_signed = (op == exec_pkg::DIV_DIV) | (op == exec_pkg::DIV_REM);
  assign a_neg     = op_signed & issue.port_a[`XLEN-1];
  assign b_neg     = op_signed & issue.port_b[`XLEN-1];

  // busy runs through the ready cycle, so a late issue is dropped too
  assign busy  = (state != exec_pkg::DIV_IDLE) | ready_q;
  assign start = (issue.unit == exec_pkg::UNIT_DIV) & ~busy;

  // one restoring step
  assign rem_shift = {rem_q, quo_q[`XLEN-1]};
  assign diff      = rem_shift - {1'b0, divisor_q};

  always_ff @(posedge CLK or negedge nRST) begin
    if (~nRST) begin
      state <= exec_pkg::DIV_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        exec_pkg::DIV_IDLE: begin
          cnt <= '0;
          if (start) begin
            state <= (issue.port_b == '0) ? exec_pkg::DIV_FINISH : exec_pkg::DIV_RUN;
          end
        end
        exec_pkg::DIV_RUN: begin
          cnt <= cnt + 1'b1;
          if (cnt == CW'(`DIV_ITERS - 1)) begin
            state <= exec_pkg::DIV_FINISH;
          end
        end
        default: state <= exec_pkg::DIV_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (start) begin
      op_q       <= op;
      rd_q       <= issue.rd;
      index_q    <= issue.index;
      dividend_q <= issue.port_a;
      divisor_q  <= b_neg ? -issue.port_b : issue.port_b;
      quo_q      <= a_neg ? -issue.port_a : issue.port_a;
      rem_q      <= '0;
      neg_quo_q  <= a_neg ^ b_neg;
      neg_rem_q  <= a_neg;
      zero_q     <= (issue.port_b == '0);
      ovf_q      <= op_signed & (issue.port_a == {1'b1, {(`XLEN-1){1'b0}}}) &
                    (issue.port_b == '1);
    end else if (state == exec_pkg::DIV_RUN) begin
      if (!diff[`XLEN]) begin
        rem_q <= diff[`XLEN-1:0];
        quo_q <= {quo_q[`XLEN-2:0], 1'b1};
      end else begin
        rem_q <= rem_shift[`XLEN-1:0];
        quo_q <= {quo_q[`XLEN-2:0], 1'b0};
      end
    end
  end

  // sign fixup, then the divide by zero and overflow cases
  always_comb begin
    quo_fix = neg_quo_q ? -quo_q : quo_q;
    rem_fix = neg_rem_q ? -rem_q : rem_q;
    if (zero_q) begin
      quo_fix = '1;
      rem_fix = dividend_q;
    end else if (ovf_q) begin
      quo_fix = dividend_q;
      rem_fix = '0;
    end
    result = ((op_q == exec_pkg::DIV_REM) | (op_q == exec_pkg::DIV_REMU)) ? rem_fix : quo_fix;
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (~nRST) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= (state == exec_pkg::DIV_FINISH);
    end
  end

  always_ff @(posedge CLK) begin
    if (state == exec_pkg::DIV_FINISH) begin
      result_q <= result;
    end
  end

  always_comb begin
    cb       = '0;
    cb.ready = ready_q;
    cb.wen   = ready_q;
    cb.rd    = rd_q;
    cb.index = index_q;
    cb.wdata = result_q;
  end

endmodule

// File: hw/exec_macros.svh
// widths and latencies for data words, registers, completion buffer, multiplier and divider
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// data word and address width
`define XLEN 32

// architectural register file size
`define REG_COUNT 32

// completion buffer depth and thus the tag width
`define NUM_CB_ENTRY 16

// multiplier latency in cycles
`define MUL_STAGES 3

// one quotient bit per iteration
`define DIV_ITERS 32

`endif

// File: hw/exec_pkg.sv
// execute stage types: data and tag vectors, op and state enums, issue, completion and redirect
`include "exec_macros.svh"

package exec_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;
  typedef logic [$clog2(`NUM_CB_ENTRY)-1:0] cb_index_t;

  // wide enough for the largest op enum below
  typedef logic [3:0] op_t;

  typedef enum logic [2:0] {
    UNIT_NONE,
    UNIT_ALU,
    UNIT_BRANCH,
    UNIT_JUMP,
    UNIT_MUL,
    UNIT_DIV
  } unit_sel_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } alu_op_e;

  // jal and jalr share the branch op field
  typedef enum logic [2:0] {
    BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } br_op_e;

  typedef enum logic [1:0] {MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU} mul_op_e;

  typedef enum logic [1:0] {DIV_DIV, DIV_DIVU, DIV_REM, DIV_REMU} div_op_e;

  typedef enum logic [1:0] {DIV_IDLE, DIV_RUN, DIV_FINISH} div_state_e;

  // one issued operation, live when unit is not UNIT_NONE
  typedef struct packed {
    unit_sel_e unit;
    op_t       op;
    word_t     pc;
    word_t     port_a;
    word_t     port_b;
    word_t     imm;
    logic      prediction;
    reg_idx_t  rd;
    cb_index_t index;
  } issue_t;

  // completion buffer write port, always accepted
  typedef struct packed {
    logic      ready;
    logic      wen;
    reg_idx_t  rd;
    cb_index_t index;
    word_t     wdata;
  } cb_port_t;

  typedef struct packed {
    logic  valid;
    word_t addr;
  } redirect_t;

endpackage

// File: hw/mult_pipe.sv
// pipelined multiplier with a tag delay line, driving the multiply completion port
`timescale 1ns/1ps
`include "exec_macros.svh"

module mult_pipe #(
  parameter int STAGES = `MUL_STAGES
) (
  input  logic               CLK,
  input  logic               nRST,
  input  exec_pkg::issue_t   issue,
  output exec_pkg::cb_port_t cb
);

  localparam int PW = 2 * `XLEN;

  logic                     is_mul;
  exec_pkg::mul_op_e        op;
  logic                     a_signed;
  logic                     b_signed;
  logic signed [`XLEN:0]    a_ext;
  logic signed [`XLEN:0]    b_ext;
  logic signed [PW+1:0]     full_prod;

  // tag delay line beside the product
  logic [STAGES-1:0]        valid_q;
  exec_pkg::reg_idx_t       rd_q    [STAGES];
  exec_pkg::cb_index_t      index_q [STAGES];
  logic [PW-1:0]            prod_q  [STAGES];
  logic                     hi_q    [STAGES];

  assign is_mul = (issue.unit == exec_pkg::UNIT_MUL);
  assign op     = exec_pkg::mul_op_e'(issue.op[1:0]);

  // mulhsu treats only the first operand as signed
  assign a_signed = (op == exec_pkg::MUL_MULH) | (op == exec_pkg::MUL_MULHSU);
  assign b_signed = (op == exec_pkg::MUL_MULH);

  assign a_ext     = {a_signed & issue.port_a[`XLEN-1], issue.port_a};
  assign b_ext     = {b_signed & issue.port_b[`XLEN-1], issue.port_b};
  assign full_prod = (PW+2)'(a_ext) * (PW+2)'(b_ext);

  always_ff @(posedge CLK or negedge nRST) begin
    if (~nRST) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= is_mul;
      for (int i = 1; i < STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // product formed in the first stage, then carried along
  always_ff @(posedge CLK) begin
    prod_q[0]  <= full_prod[PW-1:0];
    hi_q[0]    <= (op != exec_pkg::MUL_MUL);
    rd_q[0]    <= issue.rd;
    index_q[0] <= issue.index;
    for (int i = 1; i < STAGES; i++) begin
      prod_q[i]  <= prod_q[i-1];
      hi_q[i]    <= hi_q[i-1];
      rd_q[i]    <= rd_q[i-1];
      index_q[i] <= index_q[i-1];
    end
  end

  always_comb begin
    cb       = '0;
    cb.ready = valid_q[STAGES-1];
    cb.wen   = valid_q[STAGES-1];
    cb.rd    = rd_q[STAGES-1];
    cb.index = index_q[STAGES-1];
    cb.wdata = hi_q[STAGES-1] ? prod_q[STAGES-1][PW-1:`XLEN] : prod_q[STAGES-1][`XLEN-1:0];
  end

endmodule

// File: hw/ooo_execute.sv
// execute stage top: routes the issued operation to the four units and exposes their ports
`timescale 1ns/1ps

module ooo_execute (
  input  logic                CLK,
  input  logic                nRST,
  input  exec_pkg::issue_t    issue,
  output exec_pkg::cb_port_t  alu_cb,
  output exec_pkg::cb_port_t  br_cb,
  output exec_pkg::cb_port_t  mul_cb,
  output exec_pkg::cb_port_t  div_cb,
  output exec_pkg::redirect_t redirect,
  output logic                mispredict_ff,
  output logic                div_busy
);

  // each unit decodes its own select from the shared issue bus
  arith_unit arith_i (
    .issue (issue),
    .cb    (alu_cb)
  );

  // jumps reach both the ALU for the link and here for the target
  branch_resolve branch_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .issue         (issue),
    .cb            (br_cb),
    .redirect      (redirect),
    .mispredict_ff (mispredict_ff)
  );

  mult_pipe mult_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .issue (issue),
    .cb    (mul_cb)
  );

  div_unit div_i (
    .CLK   (CLK),
    .nRST  (nRST),
    .issue (issue),
    .cb    (div_cb),
    .busy  (div_busy)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator.
# The run fails if the log holds the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert \
  -f sources.f \
  --top-module tb_ooo_execute \
  -o sim_ooo_execute > "$LOG" 2>&1 \
  && ./obj_dir/sim_ooo_execute >> "$LOG" 2>&1 \
  || echo "TEST FAIL" >> "$LOG"

cat "$LOG"

grep -q "TEST FAIL" "$LOG" && exit 1 || exit 0

// File: sources.f
+incdir+hw
hw/exec_pkg.sv
hw/arith_unit.sv
hw/branch_resolve.sv
hw/mult_pipe.sv
hw/div_unit.sv
hw/ooo_execute.sv
testbench/tb_ooo_execute.sv

// File: testbench/tb_ooo_execute.sv
// execute stage testbench with clock, reset, stimulus, reference model, assertions and timeout
`timescale 1ns/1ps
`include "exec_macros.svh"

module tb_ooo_execute;

  logic                CLK;
  logic                nRST;
  exec_pkg::issue_t    issue;
  exec_pkg::cb_port_t  alu_cb;
  exec_pkg::cb_port_t  br_cb;
  exec_pkg::cb_port_t  mul_cb;
  exec_pkg::cb_port_t  div_cb;
  exec_pkg::redirect_t redirect;
  logic                mispredict_ff;
  logic                div_busy;

  // expected values updated on the falling edge
  exec_pkg::cb_port_t  exp_alu;
  exec_pkg::cb_port_t  exp_br;
  exec_pkg::cb_port_t  exp_mul;
  exec_pkg::cb_port_t  exp_div;
  exec_pkg::redirect_t exp_redir;
  exec_pkg::cb_port_t  mul_line [`MUL_STAGES+1];
  logic                exp_misp;
  logic                exp_busy;
  logic                div_armed;
  string               test_name;
  int                  cycles;
  logic [7:0]          tag;

  ooo_execute dut_i (
    .CLK           (CLK),
    .nRST          (nRST),
    .issue         (issue),
    .alu_cb        (alu_cb),
    .br_cb         (br_cb),
    .mul_cb        (mul_cb),
    .div_cb        (div_cb),
    .redirect      (redirect),
    .mispredict_ff (mispredict_ff),
    .div_busy      (div_busy)
  );

  always #50 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles > 3000) begin
      $display("run exceeded 3000 cycles without finishing");
      $display("TEST FAIL");
      $fatal(1);
    end
  end

  task automatic report_mismatch(input string port, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("[FAIL] %s %s expected %h actual %h", test_name, port, exp, act);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  function automatic logic port_ok(exec_pkg::cb_port_t act, exec_pkg::cb_port_t exp);
    return (act.ready === exp.ready) && (!exp.ready || act === exp);
  endfunction

  function automatic logic redirect_ok(exec_pkg::redirect_t act, exec_pkg::redirect_t exp);
    return (act.valid === exp.valid) && (!exp.valid || act.addr === exp.addr);
  endfunction

  a_alu: assert property (@(posedge CLK) port_ok(alu_cb, exp_alu))
    else report_mismatch("alu_cb", 64'(exp_alu), 64'($sampled(alu_cb)));
  a_br: assert property (@(posedge CLK) port_ok(br_cb, exp_br))
    else report_mismatch("br_cb", 64'(exp_br), 64'($sampled(br_cb)));
  a_mul: assert property (@(posedge CLK) port_ok(mul_cb, exp_mul))
    else report_mismatch("mul_cb", 64'(exp_mul), 64'($sampled(mul_cb)));
  a_redir: assert property (@(posedge CLK) redirect_ok(redirect, exp_redir))
    else report_mismatch("redirect", 64'(exp_redir), 64'($sampled(redirect)));
  a_misp: assert property (@(posedge CLK) mispredict_ff === exp_misp)
    else report_mismatch("mispredict_ff", 64'(exp_misp), 64'($sampled(mispredict_ff)));
  a_busy: assert property (@(posedge CLK) div_busy === exp_busy)
    else report_mismatch("div_busy", 64'(exp_busy), 64'($sampled(div_busy)));
  a_div_extra: assert property (@(posedge CLK) div_cb.ready |-> div_armed)
    else begin
      $display("divide port completed with no divide outstanding in %s", test_name);
      $display("TEST FAIL");
      $fatal(1);
    end
  a_div: assert property (@(posedge CLK) (div_cb.ready && div_armed) |-> div_cb === exp_div)
    else report_mismatch("div_cb", 64'(exp_div), 64'($sampled(div_cb)));

  function automatic exec_pkg::word_t alu_ref(logic [3:0] op, exec_pkg::word_t a,
                                              exec_pkg::word_t b);
    case (op)
      4'd0: return a + b;
      4'd1: return a - b;
      4'd2: return a & b;
      4'd3: return a | b;
      4'd4: return a ^ b;
      4'd5: return a << b[4:0];
      4'd6: return a >> b[4:0];
      4'd7: return $signed(a) >>> b[4:0];
      4'd8: return {31'b0, $signed(a) < $signed(b)};
      4'd9: return {31'b0, a < b};
      default: return '0;
    endcase
  endfunction

  function automatic logic taken_ref(logic [2:0] op, exec_pkg::word_t a, exec_pkg::word_t b);
    case (op)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd2: return $signed(a) < $signed(b);
      3'd3: return $signed(a) >= $signed(b);
      3'd4: return a < b;
      3'd5: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // operands widened to 64 bits as signed or unsigned per op
  function automatic exec_pkg::word_t mul_ref(logic [1:0] op, exec_pkg::word_t a,
                                              exec_pkg::word_t b);
    logic [63:0] ae;
    logic [63:0] be;
    logic [63:0] p;
    ae = (op == 2'd1 || op == 2'd2) ? {{32{a[31]}}, a} : {32'b0, a};
    be = (op == 2'd1) ? {{32{b[31]}}, b} : {32'b0, b};
    p  = ae * be;
    return (op == 2'd0) ? p[31:0] : p[63:32];
  endfunction

  function automatic exec_pkg::word_t div_ref(logic [1:0] op, exec_pkg::word_t a,
                                              exec_pkg::word_t b);
    logic is_rem;
    logic is_signed;
    is_rem    = (op == 2'd2 || op == 2'd3);
    is_signed = (op == 2'd0 || op == 2'd2);
    if (b == 0) begin
      return is_rem ? a : 32'hffff_ffff;
    end
    if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      return is_rem ? 32'h0 : a;
    end
    if (is_signed) begin
      return is_rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
    end
    return is_rem ? a % b : a / b;
  endfunction

  // directed corners mixed with random words
  function automatic exec_pkg::word_t pick_operand();
    case ($urandom % 6)
      0: return 32'h0;
      1: return 32'hffff_ffff;
      2: return 32'h8000_0000;
      default: return $urandom;
    endcase
  endfunction

  function automatic exec_pkg::issue_t make_issue(exec_pkg::unit_sel_e unit, logic [3:0] op,
                                                  exec_pkg::word_t a, exec_pkg::word_t b,
                                                  exec_pkg::word_t imm, logic pred);
    exec_pkg::issue_t t;
    t.unit       = unit;
    t.op         = op;
    t.pc         = $urandom & 32'hffff_fffc;
    t.port_a     = a;
    t.port_b     = b;
    t.imm        = imm;
    t.prediction = pred;
    t.rd         = tag[4:0];
    t.index      = tag[3:0] ^ tag[7:4];
    return t;
  endfunction

  // apply one issue on the falling edge and set what the next rising edge must see
  task automatic drive(input exec_pkg::issue_t t);
    logic            tk;
    exec_pkg::word_t jt;
    @(negedge CLK);
    issue    = t;
    tag      = tag + 8'd1;
    exp_misp = exp_redir.valid;
    tk       = taken_ref(t.op[2:0], t.port_a, t.port_b);
    exp_alu  = '0;
    exp_br   = '0;
    exp_redir = '0;
    if (t.unit == exec_pkg::UNIT_ALU || t.unit == exec_pkg::UNIT_JUMP) begin
      exp_alu = {1'b1, 1'b1, t.rd, t.index, 32'h0};
      exp_alu.wdata = (t.unit == exec_pkg::UNIT_JUMP) ? t.pc + 32'd4 :
                                                       alu_ref(t.op, t.port_a, t.port_b);
    end
    if (t.unit == exec_pkg::UNIT_JUMP) begin
      jt = (t.op[2:0] == 3'd7) ? ((t.port_a + t.imm) & 32'hffff_fffe) : t.pc + t.imm;
      exp_redir = {1'b1, jt};
    end
    if (t.unit == exec_pkg::UNIT_BRANCH) begin
      exp_br    = {1'b1, 1'b0, t.rd, t.index, 32'h0};
      exp_redir = {tk != t.prediction, tk ? t.pc + t.imm : t.pc + 32'd4};
    end
    for (int i = `MUL_STAGES; i > 0; i--) begin
      mul_line[i] = mul_line[i-1];
    end
    mul_line[0] = '0;
    if (t.unit == exec_pkg::UNIT_MUL) begin
      mul_line[0] = {1'b1, 1'b1, t.rd, t.index, mul_ref(t.op[1:0], t.port_a, t.port_b)};
    end
    exp_mul = mul_line[`MUL_STAGES];
  endtask

  task automatic idle(input int n);
    repeat (n) drive('0);
  endtask

  // one divide up to its ready pulse with a second divide sent while busy
  task automatic run_divide(input logic [1:0] op, input exec_pkg::word_t a,
                            input exec_pkg::word_t b);
    exec_pkg::issue_t t;
    int               n;
    logic             done;
    t = make_issue(exec_pkg::UNIT_DIV, {2'b0, op}, a, b, 32'h0, 1'b0);
    exp_div   = {1'b1, 1'b1, t.rd, t.index, div_ref(op, a, b)};
    div_armed = 1'b1;
    drive(t);
    n    = 0;
    done = 1'b0;
    while (!done) begin
      if (n == 2) begin
        drive(make_issue(exec_pkg::UNIT_DIV, 4'd0, $urandom, 32'd3, 32'h0, 1'b0));
      end else begin
        drive('0);
      end
      exp_busy = 1'b1;
      n++;
      done = div_cb.ready;
      if (n > `DIV_ITERS + 10) begin
        $display("divider gave no ready pulse in %s", test_name);
        $display("TEST FAIL");
        $fatal(1);
      end
    end
    drive('0);
    exp_busy  = 1'b0;
    div_armed = 1'b0;
    idle(2);
  endtask

  initial begin
    void'($urandom(54381));
    CLK       = 1'b0;
    nRST      = 1'b0;
    issue     = '0;
    exp_alu   = '0;
    exp_br    = '0;
    exp_mul   = '0;
    exp_div   = '0;
    exp_redir = '0;
    exp_misp  = 1'b0;
    exp_busy  = 1'b0;
    div_armed = 1'b0;
    cycles    = 0;
    tag       = 8'd1;
    for (int i = 0; i <= `MUL_STAGES; i++) begin
      mul_line[i] = '0;
    end
    test_name = "reset";
    idle(4);
    nRST = 1'b1;
    idle(2);

    test_name = "alu";
    for (int op = 0; op < 10; op++) begin
      repeat (3) begin
        drive(make_issue(exec_pkg::UNIT_ALU, 4'(op), pick_operand(), pick_operand(),
                         32'h0, 1'b0));
      end
    end

    // equal, signed-below and unsigned-below pairs give each condition both outcomes
    test_name = "branch";
    for (int op = 0; op < 6; op++) begin
      for (int pred = 0; pred < 2; pred++) begin
        drive(make_issue(exec_pkg::UNIT_BRANCH, 4'(op), 32'd5, 32'd5, 32'h40, 1'(pred)));
        drive(make_issue(exec_pkg::UNIT_BRANCH, 4'(op), 32'hffff_ffff, 32'd1,
                         32'hffff_ffc0, 1'(pred)));
        drive(make_issue(exec_pkg::UNIT_BRANCH, 4'(op), 32'd1, 32'hffff_ffff,
                         32'h80, 1'(pred)));
      end
    end

    test_name = "jump";
    drive(make_issue(exec_pkg::UNIT_JUMP, 4'd6, $urandom, 32'h0, 32'h100, 1'b0));
    drive(make_issue(exec_pkg::UNIT_JUMP, 4'd7, 32'h1000_0001, 32'h0, 32'h20, 1'b0));
    drive(make_issue(exec_pkg::UNIT_JUMP, 4'd7, $urandom, 32'h0, 32'hffff_fff3, 1'b0));
    idle(1);

    test_name = "mul";
    for (int k = 0; k < 8; k++) begin
      drive(make_issue(exec_pkg::UNIT_MUL, 4'(k % 4), pick_operand(), pick_operand(),
                       32'h0, 1'b0));
    end
    idle(`MUL_STAGES + 1);

    test_name = "div";
    for (int op = 0; op < 4; op++) begin
      run_divide(2'(op), $urandom, $urandom % 1000 + 1);
      run_divide(2'(op), pick_operand(), 32'h0);
      run_divide(2'(op), 32'h8000_0000, 32'hffff_ffff);
      run_divide(2'(op), 32'hffff_ff9c, 32'd7);
    end

    test_name = "random";
    repeat (200) begin
      case ($urandom % 4)
        0: drive(make_issue(exec_pkg::UNIT_ALU, 4'($urandom % 10), pick_operand(),
                            pick_operand(), 32'h0, 1'b0));
        1: drive(make_issue(exec_pkg::UNIT_BRANCH, 4'($urandom % 6), pick_operand(),
                            pick_operand(), $urandom & 32'hffff_fffc, 1'($urandom)));
        2: drive(make_issue(exec_pkg::UNIT_JUMP, 4'(6 + $urandom % 2), $urandom, 32'h0,
                            $urandom, 1'b0));
        default: drive(make_issue(exec_pkg::UNIT_MUL, 4'($urandom % 4), pick_operand(),
                                  pick_operand(), 32'h0, 1'b0));
      endcase
    end
    idle(`MUL_STAGES + 1);
    repeat (6) begin
      run_divide(2'($urandom % 4), pick_operand(), pick_operand());
    end

    $display("TEST PASS");
    $finish;
  end

endmodule
